/* verilog/decode_pkg.sv */
// shared types and encodings for the decode controller
// opcodes follow the standard 32-bit ORBIS encodings
// the core has a multiplier but no divider, so DIV/DIVU decode as illegal
// no SPR, MAC, FPU or custom-5 support
`default_nettype none

package decode_pkg;

	typedef logic [31:0] insn_t;
	typedef logic [4:0]  reg_addr_t;

	// major opcode, bits 31..26
	typedef enum logic [5:0] {
		J     = 6'h00, JAL   = 6'h01, BNF   = 6'h03, BF    = 6'h04,
		NOP   = 6'h05, MOVHI = 6'h06, XSYNC = 6'h08, RFE   = 6'h09,
		JR    = 6'h11, JALR  = 6'h12, LWZ   = 6'h21, LWS   = 6'h22,
		LBZ   = 6'h23, LBS   = 6'h24, LHZ   = 6'h25, LHS   = 6'h26,
		ADDI  = 6'h27, ADDIC = 6'h28, ANDI  = 6'h29, ORI   = 6'h2a,
		XORI  = 6'h2b, MULI  = 6'h2c, MFSPR = 6'h2d, SFXXI = 6'h2f,
		MTSPR = 6'h30, SW    = 6'h35, SB    = 6'h36, SH    = 6'h37,
		ALU   = 6'h38, SFXX  = 6'h39
	} opcode_t;

	// nop shares the OR code
	typedef logic [4:0] alu_op_t;
	localparam alu_op_t ALU_ADD   = 5'd0;
	localparam alu_op_t ALU_ADDC  = 5'd1;
	localparam alu_op_t ALU_SUB   = 5'd2;
	localparam alu_op_t ALU_AND   = 5'd3;
	localparam alu_op_t ALU_OR    = 5'd4;
	localparam alu_op_t ALU_XOR   = 5'd5;
	localparam alu_op_t ALU_MUL   = 5'd6;
	localparam alu_op_t ALU_SHROT = 5'd8;
	localparam alu_op_t ALU_DIV   = 5'd9;
	localparam alu_op_t ALU_DIVU  = 5'd10;
	localparam alu_op_t ALU_MULU  = 5'd11;
	localparam alu_op_t ALU_MOVHI = 5'd14;
	localparam alu_op_t ALU_COMP  = 5'd15;
	localparam alu_op_t ALU_NOP   = 5'd4;

	// bits 9..6 and 24..21
	typedef logic [3:0] alu_op2_t;
	typedef logic [3:0] comp_op_t;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0, BR_J = 3'd1, BR_JR = 3'd2,
		BR_BF  = 3'd4, BR_BNF = 3'd5, BR_RFE = 3'd6
	} branch_op_t;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0100, LSU_LBS = 4'b0101, LSU_LHZ = 4'b0110, LSU_LHS = 4'b0111,
		LSU_LWZ = 4'b1000, LSU_LWS = 4'b1001,
		LSU_SB  = 4'b1010, LSU_SH  = 4'b1100, LSU_SW  = 4'b1110
	} lsu_op_t;

	// write-back op is {source, write enable}
	typedef logic [3:0] rfwb_op_t;
	localparam logic [2:0] WB_ALU  = 3'b000;
	localparam logic [2:0] WB_LSU  = 3'b001;
	localparam logic [2:0] WB_SPRS = 3'b010;
	localparam logic [2:0] WB_LR   = 3'b011;
	localparam rfwb_op_t   RFWB_NOP = 4'b0000;

	typedef enum logic [1:0] {
		SEL_RF = 2'd0, SEL_IMM = 2'd1, SEL_EX_FORW = 2'd2, SEL_WB_FORW = 2'd3
	} sel_t;

	// bit 16 marks the bubble as pipeline filler
	localparam insn_t     NOP_INSN = {NOP, 26'h041_0000};
	localparam reg_addr_t LINK_REG = 5'd9;

	// xsync sub-codes in bits 25..23
	localparam logic [2:0] SYSCALL_SUB = 3'b000;
	localparam logic [2:0] TRAP_SUB    = 3'b010;

	// instruction field positions
	localparam int RA_LSB       = 16;
	localparam int RB_LSB       = 11;
	localparam int RD_LSB       = 21;
	localparam int IMM_W        = 16;
	localparam int BRANCH_OFS_W = 26;

endpackage

`default_nettype wire

/* verilog/insn_pipe.sv */
// ID, EX and WB instruction latches
// flush wins over freeze in ID; a bubble wins over freeze in EX
// WB latch is never flushed, only held by wb_freeze
`timescale 1ns/1ps
`default_nettype none

module insn_pipe import decode_pkg::*; (
	input  wire   clk,
	input  wire   reset,
	input  wire   id_freeze,
	input  wire   ex_freeze,
	input  wire   wb_freeze,
	input  wire   except_flushpipe,
	input  wire   pc_we,
	input  wire   extend_flush,
	input  wire   du_flush_pipe,
	input  insn_t if_insn,
	output logic  flushpipe,
	output logic  ex_bubble,
	output insn_t id_insn,
	output insn_t ex_insn,
	output insn_t wb_insn,
	output logic  id_void,
	output logic  ex_void
);

	// any of the four sources empties the front of the pipe
	assign flushpipe = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	// EX moves on while ID holds, or a flush
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	assign id_void = (id_insn[31:26] == NOP) && id_insn[16];
	assign ex_void = (ex_insn[31:26] == NOP) && ex_insn[16];

	always_ff @(posedge clk) begin
		if (reset) begin
			id_insn <= NOP_INSN;
			ex_insn <= NOP_INSN;
			wb_insn <= NOP_INSN;
		end else begin
			if (flushpipe)
				id_insn <= NOP_INSN;
			else if (!id_freeze)
				id_insn <= if_insn;

			if (ex_bubble)
				ex_insn <= NOP_INSN;
			else if (!ex_freeze)
				ex_insn <= id_insn;

			if (!wb_freeze)
				wb_insn <= ex_insn;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bubble insertion checks

	a_flush_nop: assert property (@(posedge clk) disable iff (reset)
		flushpipe |=> (id_insn == NOP_INSN));

	a_bubble_nop: assert property (@(posedge clk) disable iff (reset)
		ex_bubble |=> (ex_insn == NOP_INSN));

endmodule

`default_nettype wire

/* verilog/if_predecode.sv */
// fetch-stage predecode, register-file read ports are combinational
// id_branch_op and sel_imm land together with id_insn
`timescale 1ns/1ps
`default_nettype none

module if_predecode import decode_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        id_freeze,
	input  wire        flushpipe,
	input  insn_t      if_insn,
	output reg_addr_t  rf_addra,
	output reg_addr_t  rf_addrb,
	output logic       rf_rda,
	output logic       rf_rdb,
	output branch_op_t id_branch_op,
	output logic       sel_imm
);

	opcode_t if_op;

	assign if_op = opcode_t'(if_insn[31:26]);

	// read addresses straight from fetch
	assign rf_addra = if_insn[RA_LSB +: 5];
	assign rf_addrb = if_insn[RB_LSB +: 5];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	always_ff @(posedge clk) begin
		if (reset)
			id_branch_op <= BR_NOP;
		else if (flushpipe)
			id_branch_op <= BR_NOP;
		else if (!id_freeze) begin
			case (if_op)
				J, JAL:    id_branch_op <= BR_J;
				JR, JALR:  id_branch_op <= BR_JR;
				BNF:       id_branch_op <= BR_BNF;
				BF:        id_branch_op <= BR_BF;
				RFE:       id_branch_op <= BR_RFE;
				default:   id_branch_op <= BR_NOP;
			endcase
		end
	end

	// second operand from the immediate unless register form
	always_ff @(posedge clk) begin
		if (reset)
			sel_imm <= 1'b0;
		else if (!id_freeze) begin
			case (if_op)
				JALR, JR, RFE, MFSPR, MTSPR, XSYNC,
				SW, SB, SH, ALU, SFXX, NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	a_regreg_no_imm: assert property (@(posedge clk) disable iff (reset)
		(!id_freeze && (if_op == ALU || if_op == SFXX)) |=> !sel_imm);

endmodule

`default_nettype wire

/* verilog/id_decode.sv */
// ID-stage immediate, branch target and load/store decode
// purely combinational from id_insn and id_pc
// branch target is a word address, no overflow detection
`timescale 1ns/1ps
`default_nettype none

module id_decode import decode_pkg::*; (
	input  insn_t        id_insn,
	input  wire   [31:0] id_pc,
	output logic  [31:0] id_simm,
	output logic  [31:2] id_branch_addrtarget,
	output lsu_op_t      id_lsu_op
);

	opcode_t          id_op;
	logic [IMM_W-1:0] imm;
	logic [IMM_W-1:0] split_imm;
	logic [29:0]      ofs_ext;

	assign id_op = opcode_t'(id_insn[31:26]);
	assign imm   = id_insn[IMM_W-1:0];

	// stores and mtspr carry the upper bits where rD normally sits
	assign split_imm = {id_insn[RD_LSB +: 5], id_insn[10:0]};

	always_comb begin
		case (id_op)
			ADDI, ADDIC, LWZ, LWS, LBZ, LBS, LHZ, LHS, MULI, XORI, SFXXI:
				id_simm = {{(32-IMM_W){imm[IMM_W-1]}}, imm};
			SW, SB, SH:
				id_simm = {{(32-IMM_W){split_imm[IMM_W-1]}}, split_imm};
			MTSPR:
				id_simm = {{(32-IMM_W){1'b0}}, split_imm};
			default:
				id_simm = {{(32-IMM_W){1'b0}}, imm};
		endcase
	end

	// pc relative, offset counts words
	assign ofs_ext = {{(30-BRANCH_OFS_W){id_insn[BRANCH_OFS_W-1]}},
		id_insn[BRANCH_OFS_W-1:0]};
	assign id_branch_addrtarget = ofs_ext + id_pc[31:2];

	always_comb begin
		case (id_op)
			LWZ:     id_lsu_op = LSU_LWZ;
			LWS:     id_lsu_op = LSU_LWS;
			LBZ:     id_lsu_op = LSU_LBZ;
			LBS:     id_lsu_op = LSU_LBS;
			LHZ:     id_lsu_op = LSU_LHZ;
			LHS:     id_lsu_op = LSU_LHS;
			SW:      id_lsu_op = LSU_SW;
			SB:      id_lsu_op = LSU_SB;
			SH:      id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/ex_ctrl.sv */
// EX-stage control, registered from id_insn when ex_freeze is low
// a bubble loads no-op values, even under ex_freeze
// ex_simm and the branch target just follow ID, bubble or not
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl import decode_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire          ex_freeze,
	input  wire          ex_bubble,
	input  insn_t        id_insn,
	input  branch_op_t   id_branch_op,
	input  wire   [31:0] id_simm,
	input  wire   [31:2] id_branch_addrtarget,
	input  wire          du_hwbkpt,
	output alu_op_t      alu_op,
	output alu_op2_t     alu_op2,
	output comp_op_t     comp_op,
	output rfwb_op_t     rfwb_op,
	output reg_addr_t    rf_addrw,
	output branch_op_t   ex_branch_op,
	output logic         except_illegal,
	output logic         sig_syscall,
	output logic         sig_trap,
	output logic  [31:0] ex_simm,
	output logic  [31:2] ex_branch_addrtarget
);

	opcode_t   id_op;
	alu_op_t   alu_op_d;
	rfwb_op_t  rfwb_op_d;
	reg_addr_t rf_addrw_d;
	logic      illegal_d;
	logic      is_div;

	assign id_op  = opcode_t'(id_insn[31:26]);
	assign is_div = (id_insn[4:0] == ALU_DIV) || (id_insn[4:0] == ALU_DIVU);

	//////////////////////////////////////////////////////////////////////
	// next-state decode

	always_comb begin
		case (id_op)
			MOVHI:       alu_op_d = ALU_MOVHI;
			ADDI:        alu_op_d = ALU_ADD;
			ADDIC:       alu_op_d = ALU_ADDC;
			ANDI:        alu_op_d = ALU_AND;
			ORI:         alu_op_d = ALU_OR;
			XORI:        alu_op_d = ALU_XOR;
			MULI:        alu_op_d = ALU_MUL;
			SFXXI, SFXX: alu_op_d = ALU_COMP;
			// function bits 3..0 of the register form
			ALU:         alu_op_d = {1'b0, id_insn[3:0]};
			default:     alu_op_d = ALU_NOP;
		endcase
	end

	always_comb begin
		case (id_op)
			JAL, JALR:
				rfwb_op_d = {WB_LR, 1'b1};
			LWZ, LWS, LBZ, LBS, LHZ, LHS:
				rfwb_op_d = {WB_LSU, 1'b1};
			MOVHI, ADDI, ADDIC, ANDI, ORI, XORI, MULI, ALU:
				rfwb_op_d = {WB_ALU, 1'b1};
			MFSPR:
				rfwb_op_d = {WB_SPRS, 1'b1};
			default:
				rfwb_op_d = RFWB_NOP;
		endcase
	end

	// jump-and-link always targets r9
	assign rf_addrw_d = (id_op == JAL || id_op == JALR) ? LINK_REG : id_insn[RD_LSB +: 5];

	always_comb begin
		case (id_op)
			J, JAL, JALR, JR, BNF, BF, RFE, MOVHI, MFSPR, XSYNC,
			LWZ, LWS, LBZ, LBS, LHZ, LHS, ADDI, ADDIC, ANDI, ORI, XORI,
			MULI, SFXXI, MTSPR, SW, SB, SH, SFXX, NOP:
				illegal_d = 1'b0;
			// no divider in this core
			ALU:
				illegal_d = is_div;
			default:
				illegal_d = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// EX registers

	always_ff @(posedge clk) begin
		if (reset || ex_bubble) begin
			alu_op         <= ALU_NOP;
			alu_op2        <= '0;
			comp_op        <= '0;
			rfwb_op        <= RFWB_NOP;
			rf_addrw       <= '0;
			ex_branch_op   <= BR_NOP;
			except_illegal <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op         <= alu_op_d;
			alu_op2        <= id_insn[9:6];
			comp_op        <= id_insn[24:21];
			rfwb_op        <= rfwb_op_d;
			rf_addrw       <= rf_addrw_d;
			ex_branch_op   <= id_branch_op;
			except_illegal <= illegal_d;
			sig_syscall    <= (id_insn[31:23] == {XSYNC, SYSCALL_SUB});
			sig_trap       <= (id_insn[31:23] == {XSYNC, TRAP_SUB}) || du_hwbkpt;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_simm              <= id_simm;
			ex_branch_addrtarget <= id_branch_addrtarget;
		end
	end

	a_bubble_no_wb: assert property (@(posedge clk) disable iff (reset)
		ex_bubble |=> (rfwb_op == RFWB_NOP));

endmodule

`default_nettype wire

/* verilog/operand_forward.sv */
// ALU operand source selects for the instruction in ID
// EX result has priority over the WB result
// wbforw_valid qualifies the WB match, driven from outside
`timescale 1ns/1ps
`default_nettype none

module operand_forward import decode_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  wire       wb_freeze,
	input  insn_t     id_insn,
	input  wire       sel_imm,
	input  reg_addr_t rf_addrw,
	input  rfwb_op_t  rfwb_op,
	input  wire       wbforw_valid,
	output sel_t      sel_a,
	output sel_t      sel_b
);

	reg_addr_t wb_rfaddrw;
	reg_addr_t src_a;
	reg_addr_t src_b;

	assign src_a = id_insn[RA_LSB +: 5];
	assign src_b = id_insn[RB_LSB +: 5];

	// destination of the instruction now in WB
	always_ff @(posedge clk) begin
		if (reset)
			wb_rfaddrw <= '0;
		else if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	always_comb begin
		if (src_a == rf_addrw && rfwb_op[0])
			sel_a = SEL_EX_FORW;
		else if (src_a == wb_rfaddrw && wbforw_valid)
			sel_a = SEL_WB_FORW;
		else
			sel_a = SEL_RF;
	end

	// immediate overrides any register match
	always_comb begin
		if (sel_imm)
			sel_b = SEL_IMM;
		else if (src_b == rf_addrw && rfwb_op[0])
			sel_b = SEL_EX_FORW;
		else if (src_b == wb_rfaddrw && wbforw_valid)
			sel_b = SEL_WB_FORW;
		else
			sel_b = SEL_RF;
	end

endmodule

`default_nettype wire

/* verilog/decode_ctrl.sv */
// decode controller top, 32-bit five-stage core
// IF->ID one edge, ID->EX one edge on !ex_freeze, EX->WB on !wb_freeze
// no back-pressure beyond the three freeze levels
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl import decode_pkg::*; (
	input  wire          clk,
	input  wire          reset,
	input  wire          id_freeze,
	input  wire          ex_freeze,
	input  wire          wb_freeze,
	input  wire          except_flushpipe,
	input  wire          pc_we,
	input  wire          extend_flush,
	input  wire          du_flush_pipe,
	input  insn_t        if_insn,
	input  wire   [31:0] id_pc,
	input  wire          wbforw_valid,
	input  wire          du_hwbkpt,
	output logic         flushpipe,
	output insn_t        id_insn,
	output insn_t        ex_insn,
	output insn_t        wb_insn,
	output reg_addr_t    rf_addra,
	output reg_addr_t    rf_addrb,
	output logic         rf_rda,
	output logic         rf_rdb,
	output logic  [31:0] id_simm,
	output logic  [31:0] ex_simm,
	output logic  [31:2] id_branch_addrtarget,
	output logic  [31:2] ex_branch_addrtarget,
	output branch_op_t   id_branch_op,
	output branch_op_t   ex_branch_op,
	output lsu_op_t      id_lsu_op,
	output alu_op_t      alu_op,
	output alu_op2_t     alu_op2,
	output comp_op_t     comp_op,
	output rfwb_op_t     rfwb_op,
	output reg_addr_t    rf_addrw,
	output sel_t         sel_a,
	output sel_t         sel_b,
	output logic         except_illegal,
	output logic         sig_syscall,
	output logic         sig_trap,
	output logic         id_void,
	output logic         ex_void
);

	logic ex_bubble;
	logic sel_imm;

	insn_pipe u_insn_pipe (
		.clk, .reset, .id_freeze, .ex_freeze, .wb_freeze,
		.except_flushpipe, .pc_we, .extend_flush, .du_flush_pipe,
		.if_insn, .flushpipe, .ex_bubble,
		.id_insn, .ex_insn, .wb_insn, .id_void, .ex_void
	);

	if_predecode u_if_predecode (
		.clk, .reset, .id_freeze, .flushpipe, .if_insn,
		.rf_addra, .rf_addrb, .rf_rda, .rf_rdb, .id_branch_op, .sel_imm
	);

	id_decode u_id_decode (
		.id_insn, .id_pc, .id_simm, .id_branch_addrtarget, .id_lsu_op
	);

	ex_ctrl u_ex_ctrl (
		.clk, .reset, .ex_freeze, .ex_bubble, .id_insn, .id_branch_op,
		.id_simm, .id_branch_addrtarget, .du_hwbkpt,
		.alu_op, .alu_op2, .comp_op, .rfwb_op, .rf_addrw, .ex_branch_op,
		.except_illegal, .sig_syscall, .sig_trap, .ex_simm, .ex_branch_addrtarget
	);

	// forwarding compares ID sources against the EX destination
	operand_forward u_operand_forward (
		.clk, .reset, .wb_freeze, .id_insn, .sel_imm, .rf_addrw, .rfwb_op,
		.wbforw_valid, .sel_a, .sel_b
	);

endmodule

`default_nettype wire

/* verification/tb_decode_ctrl.sv */
// directed testbench for the decode controller
// inputs change on the falling edge, outputs are sampled there too
// register fields and immediates come from a 32-bit Fibonacci LFSR
`timescale 1ns/1ps
`default_nettype none

module tb_decode_ctrl import decode_pkg::*; ();

	logic        clk;
	logic        reset;
	logic        id_freeze;
	logic        ex_freeze;
	logic        wb_freeze;
	logic        except_flushpipe;
	logic        pc_we;
	logic        extend_flush;
	logic        du_flush_pipe;
	insn_t       if_insn;
	logic [31:0] id_pc;
	logic        wbforw_valid;
	logic        du_hwbkpt;

	logic        flushpipe;
	insn_t       id_insn;
	insn_t       ex_insn;
	insn_t       wb_insn;
	reg_addr_t   rf_addra;
	reg_addr_t   rf_addrb;
	logic        rf_rda;
	logic        rf_rdb;
	logic [31:0] id_simm;
	logic [31:0] ex_simm;
	logic [31:2] id_branch_addrtarget;
	logic [31:2] ex_branch_addrtarget;
	branch_op_t  id_branch_op;
	branch_op_t  ex_branch_op;
	lsu_op_t     id_lsu_op;
	alu_op_t     alu_op;
	alu_op2_t    alu_op2;
	comp_op_t    comp_op;
	rfwb_op_t    rfwb_op;
	reg_addr_t   rf_addrw;
	sel_t        sel_a;
	sel_t        sel_b;
	logic        except_illegal;
	logic        sig_syscall;
	logic        sig_trap;
	logic        id_void;
	logic        ex_void;

	int          value_errors = 0;
	int          other_errors = 0;
	logic [31:0] lfsr = 32'hf3f7b81b;

	decode_ctrl u_dut (.*);

	// 100 ns period
	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers

	// taps 32, 22, 2, 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step per bit taken
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// register form, func in bits 4..0
	function automatic insn_t alu_insn(input reg_addr_t rd, input reg_addr_t ra,
		input reg_addr_t rb, input alu_op_t func);
		return {ALU, rd, ra, rb, 6'b0, func};
	endfunction

	// one rising edge, back on the falling edge
	task automatic next_cycle();
		@(negedge clk);
	endtask

	task automatic drain_pipe();
		if_insn = NOP_INSN;
		repeat (3) next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_insn(input string name, input insn_t exp, input insn_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_reg_addr(input string name, input reg_addr_t exp,
		input reg_addr_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_alu_op2(input string name, input alu_op2_t exp,
		input alu_op2_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_comp_op(input string name, input comp_op_t exp,
		input comp_op_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_lsu_op(input string name, input lsu_op_t exp,
		input lsu_op_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_rfwb_op(input string name, input rfwb_op_t exp,
		input rfwb_op_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_sel(input string name, input sel_t exp, input sel_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_branch_op(input string name, input branch_op_t exp,
		input branch_op_t act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic verify_reset_state();
		int n;
		n = 0;
		// bubble should already sit in ID
		while (!id_void && n < 8) begin
			next_cycle();
			n++;
		end
		if (!id_void) begin
			$display("timed out waiting for a bubble in ID after reset");
			other_errors++;
		end
		check_insn("id_insn", NOP_INSN, id_insn);
		check_insn("ex_insn", NOP_INSN, ex_insn);
		check_insn("wb_insn", NOP_INSN, wb_insn);
		check_alu_op("alu_op", ALU_NOP, alu_op);
		check_rfwb_op("rfwb_op", RFWB_NOP, rfwb_op);
		check_branch_op("ex_branch_op", BR_NOP, ex_branch_op);
		check_reg_addr("rf_addrw", 5'd0, rf_addrw);
		check_bit("except_illegal", 1'b0, except_illegal);
		check_bit("sig_syscall", 1'b0, sig_syscall);
		check_bit("sig_trap", 1'b0, sig_trap);
		check_bit("flushpipe", 1'b0, flushpipe);
		check_bit("id_void", 1'b1, id_void);
		check_bit("ex_void", 1'b1, ex_void);
	endtask

	task automatic addi_and_store();
		logic [31:0] r;
		reg_addr_t   rd;
		reg_addr_t   ra;
		reg_addr_t   rb;
		logic [15:0] imm;
		logic [4:0]  hi;
		logic [10:0] lo;
		insn_t       addi;
		insn_t       store;
		random_bits(5, r);
		rd = r[4:0];
		random_bits(5, r);
		ra = r[4:0];
		random_bits(5, r);
		rb = r[4:0];
		random_bits(16, r);
		imm = r[15:0];
		random_bits(5, r);
		hi = r[4:0];
		random_bits(11, r);
		lo = r[10:0];
		addi = {ADDI, rd, ra, imm};
		store = {SW, hi, ra, rb, lo};
		if_insn = addi;
		next_cycle();
		check_insn("id_insn", addi, id_insn);
		check_word("id_simm", {{16{imm[15]}}, imm}, id_simm);
		check_lsu_op("id_lsu_op", LSU_NOP, id_lsu_op);
		check_bit("id_void", 1'b0, id_void);
		// addi reads rA only
		check_reg_addr("rf_addra", ra, rf_addra);
		check_bit("rf_rda", 1'b1, rf_rda);
		check_bit("rf_rdb", 1'b0, rf_rdb);
		if_insn = store;
		next_cycle();
		// store immediate is split around rB
		check_insn("id_insn", store, id_insn);
		check_word("id_simm", {{16{hi[4]}}, hi, lo}, id_simm);
		check_lsu_op("id_lsu_op", LSU_SW, id_lsu_op);
		// store reads both rA and rB
		check_reg_addr("rf_addra", ra, rf_addra);
		check_reg_addr("rf_addrb", rb, rf_addrb);
		check_bit("rf_rda", 1'b1, rf_rda);
		check_bit("rf_rdb", 1'b1, rf_rdb);
		check_alu_op("alu_op", ALU_ADD, alu_op);
		check_rfwb_op("rfwb_op", {WB_ALU, 1'b1}, rfwb_op);
		check_reg_addr("rf_addrw", rd, rf_addrw);
		// bits 9..6 and 24..21 of the addi word
		check_alu_op2("alu_op2", imm[9:6], alu_op2);
		check_comp_op("comp_op", rd[3:0], comp_op);
		check_bit("ex_void", 1'b0, ex_void);
		if_insn = NOP_INSN;
		next_cycle();
		check_insn("wb_insn", addi, wb_insn);
		check_rfwb_op("rfwb_op", RFWB_NOP, rfwb_op);
		check_word("ex_simm", {{16{hi[4]}}, hi, lo}, ex_simm);
		// nop in fetch reads nothing
		check_bit("rf_rda", 1'b0, rf_rda);
		drain_pipe();
	endtask

	task automatic jump_and_link();
		logic [31:0] r;
		logic [25:0] ofs;
		logic [31:0] pc;
		logic [29:0] target;
		random_bits(26, r);
		ofs = r[25:0];
		random_bits(32, r);
		pc = r;
		// word offset, sign-extended, added to the word pc
		target = pc[31:2] + {{4{ofs[25]}}, ofs};
		if_insn = {JAL, ofs};
		id_pc = pc;
		next_cycle();
		if_insn = NOP_INSN;
		check_branch_op("id_branch_op", BR_J, id_branch_op);
		check_word("id_branch_addrtarget", {target, 2'b00}, {id_branch_addrtarget, 2'b00});
		next_cycle();
		check_reg_addr("rf_addrw", LINK_REG, rf_addrw);
		check_rfwb_op("rfwb_op", {WB_LR, 1'b1}, rfwb_op);
		check_branch_op("ex_branch_op", BR_J, ex_branch_op);
		check_word("ex_branch_addrtarget", {target, 2'b00}, {ex_branch_addrtarget, 2'b00});
		drain_pipe();
	endtask

	task automatic forwarding_selects();
		logic [31:0] r;
		reg_addr_t   d1;
		reg_addr_t   d2;
		reg_addr_t   other;
		random_bits(5, r);
		d1 = r[4:0];
		// distinct from d1 and from each other
		d2 = d1 ^ 5'h1f;
		other = d1 ^ 5'h0a;
		random_bits(5, r);
		wbforw_valid = 1'b1;
		if_insn = alu_insn(d1, r[4:0], r[4:0], ALU_ADD);
		next_cycle();
		if_insn = alu_insn(d2, d1, r[4:0], ALU_ADD);
		next_cycle();
		// source matches the destination now in EX
		check_sel("sel_a", SEL_EX_FORW, sel_a);
		if_insn = alu_insn(other, other, d1, ALU_ADD);
		next_cycle();
		// rb matches only the older destination in WB
		check_sel("sel_a", SEL_RF, sel_a);
		check_sel("sel_b", SEL_WB_FORW, sel_b);
		if_insn = {ADDI, other, d2, 16'h0001};
		// d2 now sits in WB only, with WB forwarding off
		wbforw_valid = 1'b0;
		next_cycle();
		check_sel("sel_a", SEL_RF, sel_a);
		check_sel("sel_b", SEL_IMM, sel_b);
		drain_pipe();
	endtask

	task automatic flush_and_freeze();
		logic [31:0] r;
		reg_addr_t   rd;
		logic [15:0] imm;
		insn_t       x;
		insn_t       y;
		random_bits(5, r);
		rd = r[4:0];
		random_bits(16, r);
		imm = r[15:0];
		x = {ADDI, rd, rd, imm};
		y = {LWZ, rd ^ 5'h01, rd, ~imm};
		// flush drops the fetched instruction
		if_insn = x;
		pc_we = 1'b1;
		next_cycle();
		check_bit("flushpipe", 1'b1, flushpipe);
		pc_we = 1'b0;
		check_insn("id_insn", NOP_INSN, id_insn);
		check_insn("ex_insn", NOP_INSN, ex_insn);
		next_cycle();
		check_bit("flushpipe", 1'b0, flushpipe);
		check_insn("id_insn", x, id_insn);
		// ID held, EX gets a bubble
		id_freeze = 1'b1;
		if_insn = y;
		next_cycle();
		check_insn("id_insn", x, id_insn);
		check_insn("ex_insn", NOP_INSN, ex_insn);
		check_rfwb_op("rfwb_op", RFWB_NOP, rfwb_op);
		id_freeze = 1'b0;
		next_cycle();
		check_insn("id_insn", y, id_insn);
		check_insn("ex_insn", x, ex_insn);
		// everything held, a jump waits in fetch
		id_freeze = 1'b1;
		ex_freeze = 1'b1;
		wb_freeze = 1'b1;
		if_insn = {J, 26'h0};
		repeat (2) next_cycle();
		check_insn("id_insn", y, id_insn);
		check_insn("ex_insn", x, ex_insn);
		check_insn("wb_insn", NOP_INSN, wb_insn);
		check_alu_op("alu_op", ALU_ADD, alu_op);
		check_rfwb_op("rfwb_op", {WB_ALU, 1'b1}, rfwb_op);
		check_reg_addr("rf_addrw", rd, rf_addrw);
		check_word("ex_simm", {{16{imm[15]}}, imm}, ex_simm);
		check_branch_op("id_branch_op", BR_NOP, id_branch_op);
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		// the other three flush sources, one at a time
		for (int i = 0; i < 3; i++) begin
			except_flushpipe = (i == 0);
			extend_flush = (i == 1);
			du_flush_pipe = (i == 2);
			if_insn = x;
			next_cycle();
			check_bit("flushpipe", 1'b1, flushpipe);
			check_insn("id_insn", NOP_INSN, id_insn);
		end
		except_flushpipe = 1'b0;
		extend_flush = 1'b0;
		du_flush_pipe = 1'b0;
		drain_pipe();
	endtask

	task automatic exception_signals();
		// unlisted opcode
		if_insn = {6'h3f, 26'h0};
		next_cycle();
		if_insn = alu_insn(5'd1, 5'd2, 5'd3, ALU_DIV);
		next_cycle();
		check_bit("except_illegal", 1'b1, except_illegal);
		if_insn = {XSYNC, SYSCALL_SUB, 23'h0};
		next_cycle();
		// divide has no hardware here
		check_bit("except_illegal", 1'b1, except_illegal);
		if_insn = {XSYNC, TRAP_SUB, 23'h0};
		next_cycle();
		check_bit("except_illegal", 1'b0, except_illegal);
		check_bit("sig_syscall", 1'b1, sig_syscall);
		check_bit("sig_trap", 1'b0, sig_trap);
		if_insn = NOP_INSN;
		next_cycle();
		check_bit("sig_syscall", 1'b0, sig_syscall);
		check_bit("sig_trap", 1'b1, sig_trap);
		// hardware breakpoint with a plain bubble in ID
		du_hwbkpt = 1'b1;
		next_cycle();
		du_hwbkpt = 1'b0;
		check_bit("sig_trap", 1'b1, sig_trap);
		next_cycle();
		check_bit("sig_trap", 1'b0, sig_trap);
		drain_pipe();
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		except_flushpipe = 1'b0;
		pc_we = 1'b0;
		extend_flush = 1'b0;
		du_flush_pipe = 1'b0;
		if_insn = NOP_INSN;
		id_pc = '0;
		wbforw_valid = 1'b0;
		du_hwbkpt = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		verify_reset_state();
		addi_and_store();
		jump_and_link();
		forwarding_selects();
		flush_and_freeze();
		exception_signals();
		$display("errors: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
verilog/decode_pkg.sv
verilog/insn_pipe.sv
verilog/if_predecode.sv
verilog/id_decode.sv
verilog/ex_ctrl.sv
verilog/operand_forward.sv
verilog/decode_ctrl.sv
verification/tb_decode_ctrl.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_decode_ctrl
FILELIST    = sources.f
OBJ_DIR     = obj_dir
PASS_MSG    = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
